//--- files.f
dma_pkg.sv
dma_arb_rr.sv
dma_request_table.sv
dma_noc_request.sv
dma_local_reader.sv
dma_initiator.sv
tb_dma_initiator.sv

//--- Makefile
SRCS := $(shell cat files.f)
SIM := obj_dir/Vtb_dma_initiator

$(SIM): files.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal --top-module tb_dma_initiator \
		-f files.f -o Vtb_dma_initiator

run: $(SIM)
	$(SIM) > sim.log 2>&1; status=$$?; cat sim.log; exit $$status
	! grep -q "Regression failed" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: run clean

//--- tb_dma_initiator.sv
// Testbench for the DMA initiator with random requests, NoC sink, memory model and packet model
module tb_dma_initiator;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int half_period = 20;
  localparam int reset_cycles = 8;
  localparam int num_requests = 60;
  localparam int cycles_per_request = 80;
  localparam int timeout_cycles = num_requests * cycles_per_request;
  // Quiet cycles after reset before the first write
  localparam int startup_cycles = 6;
  localparam logic [31:0] mem_pattern = 32'h6b1d_c3a5;

  logic                                clk;
  logic                                rst;
  logic                                table_wr_en;
  logic [dma_pkg::pos_w-1:0]           table_wr_pos;
  dma_pkg::dma_request_t               table_wr_req;
  logic                                done_en;
  logic [dma_pkg::pos_w-1:0]           done_pos;
  dma_pkg::mem_req_t                   mem_req;
  logic [31:0]                         mem_rdata;
  dma_pkg::noc_flit_t                  noc_out_flit;
  logic                                noc_out_valid;
  logic                                noc_out_ready;
  logic [dma_pkg::table_entries-1:0]   valid;

  logic [31:0] lfsr;

  // Model of the table, copy of each written entry
  dma_pkg::dma_request_t             model_req [dma_pkg::table_entries];
  logic [dma_pkg::table_entries-1:0] model_valid;
  logic [dma_pkg::table_entries-1:0] model_open;
  // Cycles left until done is driven, zero when none pending
  int                                done_wait [dma_pkg::table_entries];
  // Flits still expected in the current packet
  dma_pkg::noc_flit_t                exp_q [$];
  logic                              busy;
  logic                              pkt_final;
  logic [dma_pkg::pos_w-1:0]         cur_id;
  int                                cur_sent;

  int   cycle;
  int   writes_issued;
  int   served;
  int   flit_errors;
  int   header_errors;
  int   other_errors;
  logic timed_out;

  dma_initiator UUT (
    .clk, .rst,
    .table_wr_en, .table_wr_pos, .table_wr_req,
    .done_en, .done_pos,
    .mem_req, .mem_rdata,
    .noc_out_flit, .noc_out_valid, .noc_out_ready,
    .valid
  );

  initial begin
    clk = 1'b0;
    forever #(half_period) clk = ~clk;
  end

  //////////////////////////////////////////////////
  // Random numbers and memory contents

  // Taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic take_bits(input int n, output logic [31:0] bits);
    bits = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_next(lfsr);
      bits = {bits[30:0], lfsr[0]};
    end
  endtask

  // Word stored at each local address
  function automatic logic [31:0] mem_word(input logic [31:0] addr);
    return {addr[24:0], addr[31:25]} ^ mem_pattern;
  endfunction

  function automatic dma_pkg::noc_flit_t make_flit(input dma_pkg::flit_type_e ft,
                                                   input logic [31:0] content);
    dma_pkg::noc_flit_t f;
    f.flit_type = ft;
    f.content   = content;
    return f;
  endfunction

  //////////////////////////////////////////////////
  // Compare tasks

  task automatic compare_flit(input dma_pkg::noc_flit_t got, input dma_pkg::noc_flit_t exp);
    if (got.flit_type !== exp.flit_type || got.content !== exp.content) begin
      $display("error noc_out_flit: got type %h content %h expected type %h content %h",
               got.flit_type, got.content, exp.flit_type, exp.content);
      flit_errors++;
    end
  endtask

  task automatic check_field(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("error header.%s: got %h expected %h", name, got, exp);
      header_errors++;
    end
  endtask

  task automatic compare_header(input dma_pkg::noc_header_t got,
                                input dma_pkg::noc_header_t exp);
    check_field("dest", 32'(got.dest), 32'(exp.dest));
    check_field("pkt_class", 32'(got.pkt_class), 32'(exp.pkt_class));
    check_field("source", 32'(got.source), 32'(exp.source));
    check_field("pkt_type", 32'(got.pkt_type), 32'(exp.pkt_type));
    check_field("pkt_id", 32'(got.pkt_id), 32'(exp.pkt_id));
    check_field("req_last", 32'(got.req_last), 32'(exp.req_last));
    check_field("reserved", 32'(got.reserved), 32'(exp.reserved));
    check_field("size", 32'(got.size), 32'(exp.size));
  endtask

  //////////////////////////////////////////////////
  // Packet model

  // Header seen, check it and queue the rest of the packet
  task automatic start_packet(input logic [dma_pkg::pos_w-1:0] id,
                              input dma_pkg::noc_header_t got);
    dma_pkg::dma_request_t r;
    dma_pkg::noc_header_t  exp;
    dma_pkg::flit_type_e   ft;
    int                    remaining;
    int                    words;
    r = model_req[id];
    if (!busy) begin
      busy     = 1'b1;
      cur_id   = id;
      cur_sent = 0;
    end
    exp.dest      = r.rtile;
    exp.pkt_class = dma_pkg::dma;
    exp.source    = dma_pkg::tile_id;
    exp.pkt_id    = id;
    exp.reserved  = '0;
    if (r.dir == dma_pkg::l2r) begin
      remaining    = int'(r.size) - cur_sent;
      words        = (remaining > dma_pkg::max_payload) ? dma_pkg::max_payload : remaining;
      pkt_final    = remaining <= dma_pkg::max_payload;
      exp.pkt_type = dma_pkg::l2r_req;
      exp.req_last = pkt_final;
      exp.size     = dma_pkg::size_w'(words);
      // Remote address moves on by one word per word already sent
      exp_q.push_back(make_flit(dma_pkg::payload, r.raddr + 32'(4 * cur_sent)));
      for (int i = 0; i < words; i++) begin
        ft = (i == words - 1) ? dma_pkg::last : dma_pkg::payload;
        exp_q.push_back(make_flit(ft, mem_word(r.laddr + 32'(4 * (cur_sent + i)))));
      end
      cur_sent += words;
    end else begin
      pkt_final    = 1'b1;
      exp.pkt_type = dma_pkg::r2l_req;
      exp.req_last = 1'b1;
      exp.size     = '0;
      exp_q.push_back(make_flit(dma_pkg::payload, 32'(r.size)));
      exp_q.push_back(make_flit(dma_pkg::payload, r.raddr));
      exp_q.push_back(make_flit(dma_pkg::last, r.laddr));
    end
    compare_header(got, exp);
  endtask

  // Final flit of a request accepted, entry now waits for done
  task automatic finish_request();
    logic [31:0] bits;
    model_open[cur_id] = 1'b1;
    busy = 1'b0;
    served++;
    take_bits(3, bits);
    done_wait[cur_id] = 3 + int'(bits[2:0]);
  endtask

  task automatic check_flit(input dma_pkg::noc_flit_t got);
    dma_pkg::noc_header_t hdr;
    dma_pkg::noc_flit_t   exp;
    if (exp_q.size() == 0) begin
      if (got.flit_type != dma_pkg::header) begin
        $display("Flit of type %h arrived outside any packet", got.flit_type);
        other_errors++;
      end else begin
        hdr = dma_pkg::noc_header_t'(got.content);
        if (busy && hdr.pkt_id != cur_id) begin
          $display("Header for entry %0d while entry %0d is unfinished", hdr.pkt_id, cur_id);
          other_errors++;
        end
        if (!model_valid[hdr.pkt_id] || model_open[hdr.pkt_id]) begin
          $display("Header for entry %0d that is free or still open", hdr.pkt_id);
          other_errors++;
        end
        start_packet(hdr.pkt_id, hdr);
      end
    end else begin
      exp = exp_q.pop_front();
      compare_flit(got, exp);
      if (exp_q.size() == 0 && pkt_final) begin
        finish_request();
      end
    end
  endtask

  //////////////////////////////////////////////////
  // Stimulus

  // One done report per cycle, others wait
  task automatic drive_done();
    logic picked;
    picked = 1'b0;
    done_en <= 1'b0;
    for (int i = 0; i < dma_pkg::table_entries; i++) begin
      if (done_wait[i] > 1) begin
        done_wait[i]--;
      end else if (done_wait[i] == 1 && !picked) begin
        picked       = 1'b1;
        done_wait[i] = 0;
        done_en     <= 1'b1;
        done_pos    <= dma_pkg::pos_w'(i);
        model_valid[i] = 1'b0;
        model_open[i]  = 1'b0;
      end
    end
  endtask

  // Entry is free once both the model and the DUT show it empty
  task automatic drive_write();
    logic [31:0]               bits;
    logic [dma_pkg::pos_w-1:0] pos;
    logic                      found;
    dma_pkg::dma_request_t     req;
    table_wr_en <= 1'b0;
    if (cycle >= startup_cycles && writes_issued < num_requests) begin
      take_bits(1, bits);
      if (bits[0]) begin
        take_bits(2, bits);
        pos   = bits[dma_pkg::pos_w-1:0];
        found = 1'b0;
        for (int k = 0; k < dma_pkg::table_entries; k++) begin
          if (!found && !model_valid[pos] && !valid[pos]) begin
            found = 1'b1;
          end else if (!found) begin
            pos = pos + 1'b1;
          end
        end
        if (found) begin
          take_bits(1, bits);
          req.dir = dma_pkg::dma_dir_e'(bits[0]);
          // 1 to 40 words
          take_bits(6, bits);
          req.size = dma_pkg::size_w'(bits % 40 + 1);
          take_bits(5, bits);
          req.rtile = bits[4:0];
          take_bits(16, bits);
          req.laddr = {14'h0, bits[15:0], 2'b00};
          take_bits(24, bits);
          req.raddr = {6'h0, bits[23:0], 2'b00};
          table_wr_en  <= 1'b1;
          table_wr_pos <= pos;
          table_wr_req <= req;
          model_req[pos]   = req;
          model_valid[pos] = 1'b1;
          writes_issued++;
        end
      end
    end
  endtask

  task automatic print_counts();
    $display("Errors: flit %0d, header %0d, other %0d", flit_errors, header_errors, other_errors);
  endtask

  //////////////////////////////////////////////////
  // Main sequence

  initial begin
    logic [31:0] bits;
    logic        finished;
    rst           = 1'b1;
    table_wr_en   = 1'b0;
    table_wr_pos  = '0;
    table_wr_req  = '0;
    done_en       = 1'b0;
    done_pos      = '0;
    mem_rdata     = '0;
    noc_out_ready = 1'b0;
    lfsr          = 32'h35a6;
    model_valid   = '0;
    model_open    = '0;
    busy          = 1'b0;
    pkt_final     = 1'b0;
    cur_id        = '0;
    cur_sent      = 0;
    cycle         = 0;
    writes_issued = 0;
    served        = 0;
    flit_errors   = 0;
    header_errors = 0;
    other_errors  = 0;
    timed_out     = 1'b0;
    finished      = 1'b0;
    for (int i = 0; i < dma_pkg::table_entries; i++) begin
      done_wait[i] = 0;
    end
    repeat (reset_cycles) @(posedge clk);
    rst <= 1'b0;
    while (!finished && !timed_out) begin
      @(posedge clk);
      cycle++;
      // Memory answers one cycle after the read
      if (mem_req.rd) begin
        mem_rdata <= mem_word(mem_req.addr);
      end
      // Nothing moves before the first write
      if (writes_issued == 0 && (noc_out_valid || mem_req.rd || valid != '0)) begin
        $display("DUT active before any request: noc_out_valid %b mem_req.rd %b valid %b",
                 noc_out_valid, mem_req.rd, valid);
        other_errors++;
      end
      if (noc_out_valid && noc_out_ready) begin
        check_flit(noc_out_flit);
      end
      drive_done();
      drive_write();
      // Sink ready about 3 of 4 cycles
      take_bits(2, bits);
      noc_out_ready <= bits[1:0] != 2'b00;
      finished = writes_issued == num_requests && served == num_requests &&
                 model_valid == '0 && exp_q.size() == 0;
      if (!finished && cycle >= timeout_cycles) begin
        timed_out = 1'b1;
      end
    end
    if (timed_out) begin
      $display("Timeout after %0d cycles with %0d of %0d requests served",
               cycle, served, writes_issued);
      print_counts();
      $display("Regression failed");
    end else begin
      print_counts();
      if (flit_errors + header_errors + other_errors == 0) begin
        $display("Regression passed");
      end else begin
        $display("Regression failed");
      end
    end
    $finish;
  end

endmodule

//--- dma_initiator.sv
// DMA initiator request side with request table, request generator and local reader
module dma_initiator (
  input  logic                              clk,
  input  logic                              rst,
  // Request table writes
  input  logic                              table_wr_en,
  input  logic [dma_pkg::pos_w-1:0]         table_wr_pos,
  input  dma_pkg::dma_request_t             table_wr_req,
  // Done reports from response path
  input  logic                              done_en,
  input  logic [dma_pkg::pos_w-1:0]         done_pos,
  // Local memory
  output dma_pkg::mem_req_t                 mem_req,
  input  logic [31:0]                       mem_rdata,
  // NoC output
  output dma_pkg::noc_flit_t                noc_out_flit,
  output logic                              noc_out_valid,
  input  logic                              noc_out_ready,
  // Occupied table entries
  output logic [dma_pkg::table_entries-1:0] valid
);

  logic [dma_pkg::pos_w-1:0] read_pos;
  dma_pkg::dma_request_t     read_req;
  logic                      req_start;
  logic                      word_valid, word_ready;
  logic [31:0]               word_data;

  dma_request_table u_table (
    .clk, .rst,
    .wr_en    (table_wr_en),
    .wr_pos   (table_wr_pos),
    .wr_req   (table_wr_req),
    .done_en, .done_pos,
    .read_pos, .read_req, .valid
  );

  dma_noc_request u_noc_req (
    .clk, .rst, .valid, .read_req, .read_pos,
    .done_en, .done_pos, .req_start,
    .word_valid, .word_data, .word_ready,
    .noc_out_flit, .noc_out_valid, .noc_out_ready
  );

  // Reader takes direction straight from the selected entry
  dma_local_reader u_reader (
    .clk, .rst, .req_start,
    .req_is_l2r (read_req.dir == dma_pkg::l2r),
    .req_laddr  (read_req.laddr),
    .req_size   (read_req.size),
    .mem_req, .mem_rdata, .word_valid, .word_data, .word_ready
  );

endmodule

//--- dma_local_reader.sv
// Local memory word reader with a small FIFO feeding the request generator
module dma_local_reader (
  input  logic                       clk,
  input  logic                       rst,
  // Start of a request from the generator
  input  logic                       req_start,
  input  logic                       req_is_l2r,
  input  logic [31:0]                req_laddr,
  input  logic [dma_pkg::size_w-1:0] req_size,
  // Local memory
  output dma_pkg::mem_req_t          mem_req,
  input  logic [31:0]                mem_rdata,
  // Word stream
  output logic                       word_valid,
  output logic [31:0]                word_data,
  input  logic                       word_ready
);

  logic [31:0]                   addr;
  // Words still to be read
  logic [dma_pkg::size_w-1:0]    left;
  // Read in flight, data arrives this cycle
  logic                          rd_q;
  logic [31:0]                   fifo_mem [dma_pkg::fifo_depth];
  logic [dma_pkg::fifo_ptr_w-1:0] wr_ptr, rd_ptr;
  logic [dma_pkg::fifo_ptr_w:0]   count, in_use;
  logic                          pop;

  // Count the read in flight so the FIFO never overruns
  assign in_use      = count + {{dma_pkg::fifo_ptr_w{1'b0}}, rd_q};
  assign mem_req.rd  = (left != '0) && (in_use < (dma_pkg::fifo_ptr_w + 1)'(dma_pkg::fifo_depth));
  assign mem_req.addr = addr;

  assign pop        = word_valid && word_ready;
  assign word_valid = count != '0;
  assign word_data  = fifo_mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (rst) begin
      left   <= '0;
      rd_q   <= 1'b0;
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      rd_q <= mem_req.rd;
      if (req_start && req_is_l2r) begin
        left <= req_size;
      end else if (mem_req.rd) begin
        left <= left - 1'b1;
      end
      if (rd_q) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      count <= count + {{dma_pkg::fifo_ptr_w{1'b0}}, rd_q} - {{dma_pkg::fifo_ptr_w{1'b0}}, pop};
    end
  end

  // Address and FIFO data
  always_ff @(posedge clk) begin
    if (req_start && req_is_l2r) begin
      addr <= req_laddr;
    end else if (mem_req.rd) begin
      addr <= addr + 32'd4;
    end
    if (rd_q) begin
      fifo_mem[wr_ptr] <= mem_rdata;
    end
  end

  // Each issued read must find a free slot when its data returns
  a_no_overflow: assert property (
    @(posedge clk) disable iff (rst)
    mem_req.rd |=> (count < (dma_pkg::fifo_ptr_w + 1)'(dma_pkg::fifo_depth)) || pop
  ) else $error("reader FIFO overflow");

endmodule

//--- dma_noc_request.sv
// Request generator with entry selection, open response tracking and NoC packet FSM
module dma_noc_request (
  input  logic                              clk,
  input  logic                              rst,
  // Request table
  input  logic [dma_pkg::table_entries-1:0] valid,
  input  dma_pkg::dma_request_t             read_req,
  output logic [dma_pkg::pos_w-1:0]         read_pos,
  // Completion from response path
  input  logic                              done_en,
  input  logic [dma_pkg::pos_w-1:0]         done_pos,
  // Local reader
  output logic                              req_start,
  input  logic                              word_valid,
  input  logic [31:0]                       word_data,
  output logic                              word_ready,
  // NoC output
  output dma_pkg::noc_flit_t                noc_out_flit,
  output logic                              noc_out_valid,
  input  logic                              noc_out_ready
);

  dma_pkg::noc_req_state_e state, nxt_state;

  logic [dma_pkg::table_entries-1:0] select, nxt_select, requests;
  logic [dma_pkg::table_entries-1:0] open_resp, nxt_open_resp;
  // Words sent in earlier packets of this request
  logic [dma_pkg::size_w-1:0] sent, nxt_sent;
  // Payload flit number and length of current packet
  logic [dma_pkg::size_w-1:0] pkt_count, nxt_pkt_count;
  logic [dma_pkg::size_w-1:0] pkt_size, nxt_pkt_size;
  logic [dma_pkg::size_w-1:0] remaining, hdr_size;
  logic                       hdr_last;
  logic                       arb_free;
  dma_pkg::noc_header_t       hdr;

  //////////////////////////////////////////////////
  // Entry selection

  // Grant frozen in the req_start cycle so reader and FSM see one entry
  assign arb_free = (state == dma_pkg::idle) && !req_start;
  assign requests = valid & ~open_resp & {dma_pkg::table_entries{arb_free}};

  dma_arb_rr u_arb (
    .req     (requests),
    .gnt     (select),
    .nxt_gnt (nxt_select)
  );

  // Select one-hot to table index
  always_comb begin
    read_pos = '0;
    for (int d = 0; d < dma_pkg::table_entries; d++) begin
      if (select[d]) begin
        read_pos = read_pos | dma_pkg::pos_w'(d);
      end
    end
  end

  //////////////////////////////////////////////////
  // Header fields

  // Final packet carries whatever is left
  assign remaining = read_req.size - sent;
  assign hdr_last  = remaining <= dma_pkg::size_w'(dma_pkg::max_payload);
  assign hdr_size  = hdr_last ? remaining : dma_pkg::size_w'(dma_pkg::max_payload);

  always_comb begin
    hdr.dest      = read_req.rtile;
    hdr.pkt_class = dma_pkg::dma;
    hdr.source    = dma_pkg::tile_id;
    hdr.pkt_type  = dma_pkg::l2r_req;
    hdr.pkt_id    = read_pos;
    hdr.req_last  = hdr_last;
    hdr.reserved  = '0;
    hdr.size      = hdr_size;
    // R2L is always a single packet, size travels in its own flit
    if (state == dma_pkg::r2l_genhdr) begin
      hdr.pkt_type = dma_pkg::r2l_req;
      hdr.req_last = 1'b1;
      hdr.size     = '0;
    end
  end

  //////////////////////////////////////////////////
  // Packet FSM

  always_comb begin
    nxt_state              = state;
    nxt_sent               = sent;
    nxt_pkt_count          = pkt_count;
    nxt_pkt_size           = pkt_size;
    nxt_open_resp          = open_resp;
    noc_out_valid          = 1'b0;
    noc_out_flit.flit_type = dma_pkg::payload;
    noc_out_flit.content   = '0;
    word_ready             = 1'b0;
    case (state)
      dma_pkg::idle: begin
        nxt_sent = '0;
        if (req_start) begin
          if (read_req.dir == dma_pkg::l2r) begin
            nxt_state = dma_pkg::l2r_genhdr;
          end else begin
            nxt_state = dma_pkg::r2l_genhdr;
          end
        end
      end
      dma_pkg::l2r_genhdr: begin
        noc_out_valid          = 1'b1;
        noc_out_flit.flit_type = dma_pkg::header;
        noc_out_flit.content   = hdr;
        nxt_pkt_size           = hdr_size;
        nxt_pkt_count          = dma_pkg::size_w'(1);
        if (noc_out_ready) begin
          nxt_state = dma_pkg::l2r_genaddr;
        end
      end
      dma_pkg::l2r_genaddr: begin
        noc_out_valid        = 1'b1;
        // Remote address advances one word per word already sent
        noc_out_flit.content = read_req.raddr + {{(30 - dma_pkg::size_w){1'b0}}, sent, 2'b00};
        if (noc_out_ready) begin
          nxt_state = dma_pkg::l2r_data;
        end
      end
      dma_pkg::l2r_data: begin
        // Words pass straight from reader FIFO to NoC
        noc_out_valid        = word_valid;
        noc_out_flit.content = word_data;
        word_ready           = noc_out_ready;
        if (pkt_count == pkt_size) begin
          noc_out_flit.flit_type = dma_pkg::last;
        end
        if (word_valid && noc_out_ready) begin
          nxt_pkt_count = pkt_count + 1'b1;
          if (pkt_count == pkt_size) begin
            if (sent + pkt_count == read_req.size) begin
              nxt_open_resp = open_resp | select;
              nxt_state     = dma_pkg::idle;
            end else begin
              nxt_sent  = sent + pkt_count;
              nxt_state = dma_pkg::l2r_genhdr;
            end
          end
        end
      end
      dma_pkg::r2l_genhdr: begin
        noc_out_valid          = 1'b1;
        noc_out_flit.flit_type = dma_pkg::header;
        noc_out_flit.content   = hdr;
        if (noc_out_ready) begin
          nxt_state = dma_pkg::r2l_gensize;
        end
      end
      dma_pkg::r2l_gensize: begin
        noc_out_valid        = 1'b1;
        noc_out_flit.content = {{(32 - dma_pkg::size_w){1'b0}}, read_req.size};
        if (noc_out_ready) begin
          nxt_state = dma_pkg::r2l_genraddr;
        end
      end
      dma_pkg::r2l_genraddr: begin
        noc_out_valid        = 1'b1;
        noc_out_flit.content = read_req.raddr;
        if (noc_out_ready) begin
          nxt_state = dma_pkg::r2l_genladdr;
        end
      end
      dma_pkg::r2l_genladdr: begin
        noc_out_valid          = 1'b1;
        noc_out_flit.flit_type = dma_pkg::last;
        noc_out_flit.content   = read_req.laddr;
        if (noc_out_ready) begin
          nxt_open_resp = open_resp | select;
          nxt_state     = dma_pkg::idle;
        end
      end
      default: begin
        nxt_state = dma_pkg::idle;
      end
    endcase
    // Response path closes the entry
    if (done_en) begin
      nxt_open_resp[done_pos] = 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state     <= dma_pkg::idle;
      select    <= '0;
      open_resp <= '0;
      req_start <= 1'b0;
      sent      <= '0;
      pkt_count <= '0;
      pkt_size  <= '0;
    end else begin
      state     <= nxt_state;
      select    <= nxt_select;
      open_resp <= nxt_open_resp;
      // Pending entry seen while selection is still open
      req_start <= |requests;
      sent      <= nxt_sent;
      pkt_count <= nxt_pkt_count;
      pkt_size  <= nxt_pkt_size;
    end
  end

  //////////////////////////////////////////////////
  // Checks

  // Stalled flit must not change under the NoC
  a_flit_stable: assert property (
    @(posedge clk) disable iff (rst)
    noc_out_valid && !noc_out_ready |=> noc_out_valid && $stable(noc_out_flit)
  ) else $error("NoC flit changed while stalled");

  a_state_legal: assert property (
    @(posedge clk) disable iff (rst)
    state inside {dma_pkg::idle, dma_pkg::l2r_genhdr, dma_pkg::l2r_genaddr,
                  dma_pkg::l2r_data, dma_pkg::r2l_genhdr, dma_pkg::r2l_gensize,
                  dma_pkg::r2l_genraddr, dma_pkg::r2l_genladdr}
  ) else $error("request FSM in unlisted state %0h", state);

endmodule

//--- dma_request_table.sv
// Request table with four entries and valid bits, set by writes and cleared by done reports
module dma_request_table (
  input  logic                                clk,
  input  logic                                rst,
  // Write port from software side
  input  logic                                wr_en,
  input  logic [dma_pkg::pos_w-1:0]           wr_pos,
  input  dma_pkg::dma_request_t               wr_req,
  // Completion from response path
  input  logic                                done_en,
  input  logic [dma_pkg::pos_w-1:0]           done_pos,
  // Read port for request generator
  input  logic [dma_pkg::pos_w-1:0]           read_pos,
  output dma_pkg::dma_request_t               read_req,
  output logic [dma_pkg::table_entries-1:0]   valid
);

  //////////////////////////////////////////////////
  // Storage

  // Entry contents, only meaningful while valid
  dma_pkg::dma_request_t entries [dma_pkg::table_entries];

  always_ff @(posedge clk) begin
    if (wr_en) begin
      entries[wr_pos] <= wr_req;
    end
  end

  // Valid bits
  // Write sets, done clears, both take effect next cycle
  always_ff @(posedge clk) begin
    if (rst) begin
      valid <= '0;
    end else begin
      if (wr_en) begin
        valid[wr_pos] <= 1'b1;
      end
      if (done_en) begin
        valid[done_pos] <= 1'b0;
      end
    end
  end

  // Combinational read of the selected entry
  assign read_req = entries[read_pos];

  //////////////////////////////////////////////////
  // Checks

  // Software must wait for done before reusing an entry
  a_no_overwrite: assert property (
    @(posedge clk) disable iff (rst)
    wr_en |-> !valid[wr_pos]
  ) else $error("write to entry %0d that is still valid", wr_pos);

endmodule

//--- dma_arb_rr.sv
// Round-robin arbiter with one-hot grant that holds the grant when nothing requests
module dma_arb_rr (
  input  logic [dma_pkg::table_entries-1:0] req,
  input  logic [dma_pkg::table_entries-1:0] gnt,
  output logic [dma_pkg::table_entries-1:0] nxt_gnt
);

  // Index of current grant
  logic [dma_pkg::pos_w-1:0] cur;
  // Candidate index while rotating
  logic [dma_pkg::pos_w-1:0] idx;
  logic                      found;

  // One-hot to index, zero when no grant yet
  always_comb begin
    cur = '0;
    for (int i = 0; i < dma_pkg::table_entries; i++) begin
      if (gnt[i]) begin
        cur = dma_pkg::pos_w'(i);
      end
    end
  end

  // Search starts right after the current grant and wraps back to it
  always_comb begin
    nxt_gnt = gnt;
    found   = 1'b0;
    idx     = '0;
    for (int k = 1; k <= dma_pkg::table_entries; k++) begin
      // Index width makes the wrap implicit
      idx = cur + dma_pkg::pos_w'(k);
      if (!found && req[idx]) begin
        nxt_gnt      = '0;
        nxt_gnt[idx] = 1'b1;
        found        = 1'b1;
      end
    end
  end

endmodule

//--- dma_pkg.sv
// Sizes, flit and header types, request table entry and memory port for the DMA initiator
package dma_pkg;

  //////////////////////////////////////////////////
  // Sizes

  // NoC address of this tile
  localparam logic [4:0] tile_id = 5'd3;
  localparam int table_entries = 4;
  localparam int pos_w = 2;
  // Flits per NoC packet
  localparam int noc_packet_size = 16;
  // Header and address flit take two slots
  localparam int max_payload = noc_packet_size - 2;
  // Transfer size in words
  localparam int size_w = 12;
  // Reader FIFO
  localparam int fifo_depth = 4;
  localparam int fifo_ptr_w = 2;

  //////////////////////////////////////////////////
  // Encodings

  typedef enum logic [1:0] {
    payload = 2'b00,
    header  = 2'b01,
    last    = 2'b10
  } flit_type_e;

  typedef enum logic [2:0] {
    dma = 3'd2
  } pkt_class_e;

  typedef enum logic [1:0] {
    l2r_req = 2'd0,
    r2l_req = 2'd1
  } pkt_type_e;

  typedef enum logic {
    l2r = 1'b0,
    r2l = 1'b1
  } dma_dir_e;

  // Request generator FSM
  typedef enum logic [3:0] {
    idle         = 4'd0,
    l2r_genhdr   = 4'd1,
    l2r_genaddr  = 4'd2,
    l2r_data     = 4'd3,
    r2l_genhdr   = 4'd4,
    r2l_gensize  = 4'd5,
    r2l_genraddr = 4'd6,
    r2l_genladdr = 4'd7
  } noc_req_state_e;

  //////////////////////////////////////////////////
  // Structures

  typedef struct packed {
    flit_type_e  flit_type;
    logic [31:0] content;
  } noc_flit_t;

  // Fills the content of a header flit, MSB first
  typedef struct packed {
    logic [4:0]        dest;
    pkt_class_e        pkt_class;
    logic [4:0]        source;
    pkt_type_e         pkt_type;
    logic [pos_w-1:0]  pkt_id;
    logic              req_last;
    logic [1:0]        reserved;
    logic [size_w-1:0] size;
  } noc_header_t;

  typedef struct packed {
    dma_dir_e          dir;
    logic [4:0]        rtile;
    logic [31:0]       laddr;
    logic [31:0]       raddr;
    logic [size_w-1:0] size;
  } dma_request_t;

  typedef struct packed {
    logic        rd;
    logic [31:0] addr;
  } mem_req_t;

endpackage
